// File: aes_pkg.sv
// aes-128 shared definitions
// state layout, round count and key expansion constants

package aes_pkg;

    localparam int NB_BYTES = 16;   // bytes in the state
    localparam int NB_COLS  = 4;    // 32-bit columns in the state
    localparam int NR       = 10;   // rounds for a 128-bit key
    localparam int ROUND_W  = 4;    // round counter width

    // round constants, entry r-1 used for round r
    localparam logic [0:NR-1][7:0] RCON = {
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
        8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    // one 128-bit state word, two views
    // byte 0 is the msb of the bus, column c is bytes 4c..4c+3
    // bytes for subbytes/shiftrows, cols for mixcolumns/addroundkey
    typedef union packed {
        logic [0:NB_BYTES-1][7:0] bytes;
        logic [0:NB_COLS-1][31:0] cols;
    } aes_state_t;

endpackage

// File: aes_sbox.sv
// aes forward s-box
// combinational byte substitution, table split into 16 rows of 16 bytes

`timescale 1ns/1ps

module aes_sbox (
    input  logic [7:0] a,
    output logic [7:0] s
);

    logic [127:0] row;   // 16 entries sharing the upper nibble

    // upper nibble picks the row
    always_comb
    begin
        case (a[7:4])
            4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
            4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
            4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
            4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
            4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
            4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
            4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
            4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
            4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
            4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
            4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
            4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
            4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
            4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
            4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
            4'hf: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
            default: row = '0;
        endcase
    end

    // lower nibble picks the byte, entry 0 at the top of the row
    assign s = row[127 - 8*a[3:0] -: 8];

endmodule

// File: aes_round.sv
// one aes encryption round
// subbytes, shiftrows, mixcolumns (skipped in the final round), addroundkey

`timescale 1ns/1ps

module aes_round (
    input  aes_pkg::aes_state_t state,
    input  logic [127:0]        round_key,
    input  logic                last,        // final round, no mixcolumns
    output aes_pkg::aes_state_t next_state
);

    logic [7:0]          sb [0:aes_pkg::NB_BYTES-1];   // subbytes result
    aes_pkg::aes_state_t shift_st;                     // after shiftrows
    aes_pkg::aes_state_t mix_st;                       // after mixcolumns
    aes_pkg::aes_state_t rk;

    // multiply by x in gf(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        xtime = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // column times the fixed 02 03 01 01 circulant matrix
    function automatic logic [31:0] mix_col(input logic [31:0] col);
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        a0 = col[31:24];   // row 0
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        mix_col[31:24] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
        mix_col[23:16] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
        mix_col[15:8]  = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
        mix_col[7:0]   = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
    endfunction

    // one s-box per state byte
    genvar i;
    generate
        for (i = 0; i < aes_pkg::NB_BYTES; i++)
        begin : g_sbox
            aes_sbox u_sbox (
                .a (state.bytes[i]),
                .s (sb[i])
            );
        end
    endgenerate

    // row r rotates left by r, byte index is 4*col + row
    always_comb
    begin
        for (int c = 0; c < aes_pkg::NB_COLS; c++)
        begin
            for (int r = 0; r < 4; r++)
                shift_st.bytes[4*c + r] = sb[4*((c + r) % 4) + r];
        end
    end

    assign rk = round_key;

    // column view for mixing and key addition
    always_comb
    begin
        for (int c = 0; c < aes_pkg::NB_COLS; c++)
        begin
            mix_st.cols[c]     = last ? shift_st.cols[c] : mix_col(shift_st.cols[c]);
            next_state.cols[c] = mix_st.cols[c] ^ rk.cols[c];
        end
    end

endmodule

// File: aes_key_sched.sv
// aes-128 on-the-fly key expansion
// keeps the current round key and derives the next one combinationally

`timescale 1ns/1ps

module aes_key_sched (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        load,      // take the cipher key
    input  logic [127:0]                key,
    input  logic                        advance,   // step to next round key
    input  logic [aes_pkg::ROUND_W-1:0] round,     // round being computed, 1..10
    output logic [127:0]                next_key
);

    aes_pkg::aes_state_t cur_key;   // round key of the previous round
    logic [31:0]         rot_word;
    logic [31:0]         sub_word;
    logic [7:0]          rcon;
    logic [31:0]         temp;
    logic [31:0]         w0;
    logic [31:0]         w1;
    logic [31:0]         w2;
    logic [31:0]         w3;

    // rotword on the last word
    assign rot_word = {cur_key.cols[3][23:0], cur_key.cols[3][31:24]};

    genvar i;
    generate
        for (i = 0; i < 4; i++)
        begin : g_sbox
            aes_sbox u_sbox (
                .a (rot_word[31 - 8*i -: 8]),
                .s (sub_word[31 - 8*i -: 8])
            );
        end
    endgenerate

    // zero outside rounds 1..10, counter idles at 0 or 10
    assign rcon = (round != '0 && round <= aes_pkg::ROUND_W'(aes_pkg::NR))
                  ? aes_pkg::RCON[round - 1'b1] : 8'h00;

    assign temp = sub_word ^ {rcon, 24'h000000};

    // xor chain through the four words
    assign w0 = cur_key.cols[0] ^ temp;
    assign w1 = cur_key.cols[1] ^ w0;
    assign w2 = cur_key.cols[2] ^ w1;
    assign w3 = cur_key.cols[3] ^ w2;

    assign next_key = {w0, w1, w2, w3};

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            cur_key <= '0;
        else if (load)
            cur_key <= key;        // round key 0
        else if (advance)
            cur_key <= next_key;   // key used this round
    end

endmodule

// File: aes_state_reg.sv
// aes state register and round controller
// 16-byte state, round counter, busy/done flags and the valid/ready handshake

`timescale 1ns/1ps

module aes_state_reg (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        in_valid,
    input  aes_pkg::aes_state_t         init_state,   // plaintext xor key
    input  aes_pkg::aes_state_t         next_state,   // round datapath result
    input  logic                        out_ready,
    output logic                        in_ready,
    output logic                        out_valid,
    output aes_pkg::aes_state_t         state,
    output logic [aes_pkg::ROUND_W-1:0] round,
    output logic                        last,
    output logic                        advance,
    output logic                        load
);

    logic busy;   // rounds in progress
    logic done;   // result waiting for out_ready

    // one block in flight, no accept while busy or holding a result
    assign in_ready  = !busy && !done;
    assign load      = in_valid && in_ready;
    assign advance   = busy;
    assign last      = busy && (round == aes_pkg::ROUND_W'(aes_pkg::NR));
    assign out_valid = done;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= '0;
            round <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end
        else if (load)
        begin
            state <= init_state;
            round <= aes_pkg::ROUND_W'(1);   // first round next cycle
            busy  <= 1'b1;
        end
        else if (advance)
        begin
            state <= next_state;
            if (last)
            begin
                busy <= 1'b0;   // round 10 result now registered
                done <= 1'b1;
            end
            else
                round <= round + 1'b1;
        end
        else if (done && out_ready)
            done <= 1'b0;   // result transferred, state held until next load
    end

endmodule

// File: aes_core.sv
// iterative aes-128 encryption core
// initial key addition, then ten rounds at one per cycle, valid/ready on both sides

`timescale 1ns/1ps

module aes_core (
    input  logic         clk,
    input  logic         resetn,
    input  logic         in_valid,
    input  logic [127:0] in_data,    // plaintext, byte 0 in the msb
    input  logic [127:0] in_key,
    input  logic         out_ready,
    output logic         in_ready,
    output logic         out_valid,
    output logic [127:0] out_data    // ciphertext
);

    aes_pkg::aes_state_t         init_state;
    aes_pkg::aes_state_t         next_state;
    aes_pkg::aes_state_t         state;
    logic [aes_pkg::ROUND_W-1:0] round;
    logic                        last;
    logic                        advance;
    logic                        load;
    logic [127:0]                next_key;

    // round 0 addroundkey
    assign init_state = in_data ^ in_key;

    // handshake, state and round count
    aes_state_reg u_state_reg (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .init_state (init_state),
        .next_state (next_state),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .state      (state),
        .round      (round),
        .last       (last),
        .advance    (advance),
        .load       (load)
    );

    aes_round u_round (
        .state      (state),
        .round_key  (next_key),   // key for the current round, same cycle
        .last       (last),
        .next_state (next_state)
    );

    aes_key_sched u_key_sched (
        .clk      (clk),
        .resetn   (resetn),
        .load     (load),
        .key      (in_key),
        .advance  (advance),
        .round    (round),
        .next_key (next_key)
    );

    assign out_data = state;   // stable while out_valid, state only moves when busy

endmodule

// File: tb_clkgen.sv
// testbench clock and reset source
// 4 ns clock, resetn held low for the first 16 cycles

`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic resetn
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 250 MHz
    end

    initial
    begin
        resetn = 1'b0;
        repeat (16) @(posedge clk);
        #1 resetn = 1'b1;   // released just after an edge
    end

endmodule

// File: aes_core_assert.sv
// handshake and latency properties for the aes core
// attached to every aes_core instance by bind

`timescale 1ns/1ps

module aes_core_assert (
    input logic         clk,
    input logic         resetn,
    input logic         in_valid,
    input logic         in_ready,
    input logic         out_valid,
    input logic         out_ready,
    input logic [127:0] out_data
);

    // one block in flight, never ready for input while a result waits
    a_one_side: assert property (@(posedge clk) disable iff (!resetn)
        !(in_ready && out_valid))
        else $error("in_ready and out_valid high in the same cycle");

    // stalled result stays put
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("result changed or dropped while out_ready was low");

    // result registered at the 10th edge after acceptance, sampled one tick later
    a_latency: assert property (@(posedge clk) disable iff (!resetn)
        (in_valid && in_ready) |-> ##11 $rose(out_valid))
        else $error("out_valid did not rise 10 cycles after acceptance");

endmodule

bind aes_core aes_core_assert u_core_assert (
    .clk       (clk),
    .resetn    (resetn),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
);

// File: tb_aes.sv
// testbench for the iterative aes-128 core
// seeded random blocks with idle gaps and back-pressure, checked against a behavioral model

`timescale 1ns/1ps

module tb_aes;

    localparam int NUM_BLOCKS = 201;   // fips vector then 200 random blocks
    localparam int LATENCY    = 10;    // accept edge to out_valid edge
    localparam int MAX_STALL  = 7;
    localparam int MAX_GAP    = 20;    // long gaps outlast a block, core sits idle
    localparam int CLK_NS     = 4;
    localparam int TIMEOUT_NS = NUM_BLOCKS * (LATENCY + MAX_STALL + MAX_GAP + 4) * CLK_NS
                                + 16 * CLK_NS + 1000;

    localparam logic [127:0] FIPS_KEY = 128'h000102030405060708090a0b0c0d0e0f;
    localparam logic [127:0] FIPS_PT  = 128'h00112233445566778899aabbccddeeff;
    localparam logic [127:0] FIPS_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic         clk;
    logic         resetn;
    logic         in_valid;
    logic [127:0] in_data;
    logic [127:0] in_key;
    logic         out_ready;
    logic         in_ready;
    logic         out_valid;
    logic [127:0] out_data;

    logic [7:0]   sbox_tbl [0:255];   // model s-box, built at start
    logic [127:0] exp_q [$];          // expected ciphertexts in accept order
    int           seed;
    int           cyc;                // posedge count since reset release
    int           acc_edge;           // edge index of the last acceptance
    int           sent;
    int           done_cnt;
    int           gap_left;
    int           stall_left;
    logic         accepted;
    logic         hold_pending;
    logic         prev_valid;
    logic [127:0] hold_data;

    tb_clkgen u_clkgen (
        .clk    (clk),
        .resetn (resetn)
    );

    aes_core dut0 (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_key    (in_key),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    // shift-and-add multiply in gf(2^8) mod x^8+x^4+x^3+x+1
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        p = 8'h00;
        x = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                p = p ^ x;
            x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
        end
        return p;
    endfunction

    // multiplicative inverse by search, then the affine map
    function automatic logic [7:0] sbox_calc(input logic [7:0] a);
        logic [7:0] inv;
        inv = 8'h00;   // zero maps to zero
        for (int b = 1; b < 256; b++)
        begin
            if (gf_mul(a, 8'(b)) == 8'h01)
                inv = 8'(b);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

    // full aes-128 encryption with the whole key schedule expanded up front
    function automatic logic [127:0] aes_encrypt(input logic [127:0] key,
                                                 input logic [127:0] pt);
        logic [31:0]  w   [0:43];
        logic [7:0]   st  [0:15];
        logic [7:0]   tmp [0:15];
        logic [31:0]  t;
        logic [7:0]   rc;
        logic [7:0]   a0;
        logic [7:0]   a1;
        logic [7:0]   a2;
        logic [7:0]   a3;
        logic [127:0] res;
        rc = 8'h01;
        for (int i = 0; i < 4; i++)
            w[i] = key[127 - 32*i -: 32];
        for (int i = 4; i < 44; i++)
        begin
            t = w[i-1];
            if (i % 4 == 0)
            begin
                t = {sbox_tbl[t[23:16]], sbox_tbl[t[15:8]],
                     sbox_tbl[t[7:0]], sbox_tbl[t[31:24]]} ^ {rc, 24'h000000};
                rc = gf_mul(rc, 8'h02);   // next power of x
            end
            w[i] = w[i-4] ^ t;
        end
        for (int b = 0; b < 16; b++)
            st[b] = pt[127 - 8*b -: 8] ^ w[b/4][31 - 8*(b%4) -: 8];
        for (int rnd = 1; rnd <= 10; rnd++)
        begin
            // substitute and shift, row r reads column c+r
            for (int b = 0; b < 16; b++)
                tmp[b] = sbox_tbl[st[4*(((b/4) + (b%4)) % 4) + (b%4)]];
            for (int c = 0; c < 4; c++)
            begin
                a0 = tmp[4*c];
                a1 = tmp[4*c + 1];
                a2 = tmp[4*c + 2];
                a3 = tmp[4*c + 3];
                if (rnd < 10)
                begin
                    st[4*c]     = gf_mul(a0, 8'h02) ^ gf_mul(a1, 8'h03) ^ a2 ^ a3;
                    st[4*c + 1] = a0 ^ gf_mul(a1, 8'h02) ^ gf_mul(a2, 8'h03) ^ a3;
                    st[4*c + 2] = a0 ^ a1 ^ gf_mul(a2, 8'h02) ^ gf_mul(a3, 8'h03);
                    st[4*c + 3] = gf_mul(a0, 8'h03) ^ a1 ^ a2 ^ gf_mul(a3, 8'h02);
                end
                else
                begin
                    st[4*c]     = a0;   // no column mix in the final round
                    st[4*c + 1] = a1;
                    st[4*c + 2] = a2;
                    st[4*c + 3] = a3;
                end
            end
            for (int b = 0; b < 16; b++)
                st[b] = st[b] ^ w[4*rnd + b/4][31 - 8*(b%4) -: 8];
        end
        for (int b = 0; b < 16; b++)
            res[127 - 8*b -: 8] = st[b];
        return res;
    endfunction

    function automatic logic [127:0] rand128();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // new inputs 1 ns after the rising edge
    task automatic drive_inputs();
        if (accepted)
        begin
            in_valid = 1'b0;
            gap_left = $unsigned($random(seed)) % (MAX_GAP + 1);
        end
        if (!in_valid)
        begin
            if (gap_left > 0 || sent == NUM_BLOCKS)
            begin
                if (gap_left > 0)
                    gap_left--;
                in_data = rand128();   // junk on an idle bus
                in_key  = rand128();
            end
            else
            begin
                in_valid = 1'b1;
                in_data  = (sent == 0) ? FIPS_PT : rand128();
                in_key   = (sent == 0) ? FIPS_KEY : rand128();
                sent++;
            end
        end
        // back-pressure once a result shows up
        if (out_valid && stall_left > 0)
        begin
            out_ready = 1'b0;
            stall_left--;
        end
        else
            out_ready = 1'b1;
    endtask

    // sampled at the falling edge, everything settled
    task automatic check_outputs();
        logic [127:0] expect_ct;
        accepted = in_valid && in_ready;
        if (hold_pending)
        begin
            assert (out_valid)
            else stop_on_error($sformatf("error at %0t: out_valid expected 1, got 0", $time));
            assert (out_data == hold_data)
            else stop_on_error($sformatf("error at %0t: out_data expected %h, got %h",
                                         $time, hold_data, out_data));
        end
        hold_pending = out_valid && !out_ready;
        hold_data    = out_data;
        if (hold_pending)
        begin
            assert (!in_ready)
            else stop_on_error($sformatf("error at %0t: in_ready expected 0, got 1", $time));
        end
        if (out_valid && !prev_valid)
        begin
            assert (cyc - acc_edge == LATENCY)
            else stop_on_error($sformatf("error at %0t: out_valid latency expected %0d, got %0d",
                                         $time, LATENCY, cyc - acc_edge));
        end
        prev_valid = out_valid;
        if (accepted)
        begin
            exp_q.push_back(aes_encrypt(in_key, in_data));
            acc_edge = cyc + 1;   // transfer happens on the coming edge
        end
        if (out_valid && out_ready)
        begin
            assert (exp_q.size() > 0)
            else stop_on_error("a result came out with no block outstanding");
            expect_ct = exp_q.pop_front();
            assert (out_data == expect_ct)
            else stop_on_error($sformatf("error at %0t: out_data expected %h, got %h",
                                         $time, expect_ct, out_data));
            done_cnt++;
            if ($random(seed) & 1)
                stall_left = 0;
            else
                stall_left = $unsigned($random(seed)) % (MAX_STALL + 1);
        end
    endtask

    initial
    begin
        in_valid     = 1'b0;
        in_data      = '0;
        in_key       = '0;
        out_ready    = 1'b1;
        seed         = 32'hc6af92e1;
        cyc          = 0;
        acc_edge     = 0;
        sent         = 0;
        done_cnt     = 0;
        gap_left     = 0;
        stall_left   = 0;   // fips block sees out_ready high
        accepted     = 1'b0;
        hold_pending = 1'b0;
        prev_valid   = 1'b0;
        hold_data    = '0;
        for (int i = 0; i < 256; i++)
            sbox_tbl[i] = sbox_calc(8'(i));
        assert (aes_encrypt(FIPS_KEY, FIPS_PT) == FIPS_CT)
        else stop_on_error($sformatf("error at %0t: model ciphertext expected %h, got %h",
                                     $time, FIPS_CT, aes_encrypt(FIPS_KEY, FIPS_PT)));
        @(posedge resetn);
        @(negedge clk);
        assert (!out_valid)
        else stop_on_error($sformatf("error at %0t: out_valid expected 0, got 1", $time));
        assert (in_ready)
        else stop_on_error($sformatf("error at %0t: in_ready expected 1, got 0", $time));
        while (done_cnt < NUM_BLOCKS)
        begin
            @(posedge clk);
            cyc++;
            #1;
            drive_inputs();
            @(negedge clk);
            check_outputs();
        end
        // no extra result once every block is back
        repeat (LATENCY + 2)
        begin
            @(negedge clk);
            assert (!out_valid)
            else stop_on_error($sformatf("error at %0t: out_valid expected 0, got 1", $time));
        end
        $display("Result: PASSED");
        $finish;
    end

    // watchdog sized from block count, latency, stalls and gaps
    initial
    begin
        #(TIMEOUT_NS);
        stop_on_error($sformatf("timeout: only %0d of %0d blocks came back within %0d ns",
                                done_cnt, NUM_BLOCKS, TIMEOUT_NS));
    end

endmodule

// File: list.f
aes_pkg.sv
aes_sbox.sv
aes_round.sv
aes_key_sched.sv
aes_state_reg.sv
aes_core.sv
tb_clkgen.sv
aes_core_assert.sv
tb_aes.sv

// File: run.sh
#!/usr/bin/env bash
# build the aes-128 core testbench with verilator and run it
# the simulator exit status is the test result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module tb_aes \
    -o tb_aes_sim

./obj_dir/tb_aes_sim
